// File: hw/fetch_pkg.sv
package fetch_pkg;

    // ====================
    // Widths and sizes
    // ====================

    // Instruction, PC and immediate width
    localparam int unsigned XLEN        = 32;
    // Slots per fetch group and per decode group
    localparam int unsigned FETCH_WIDTH = 3;
    // Instruction buffer entries
    localparam int unsigned BUF_DEPTH   = 16;
    localparam int unsigned PTR_W       = 4;
    // Occupancy has to reach BUF_DEPTH itself
    localparam int unsigned OCC_W       = 5;
    // Slot count 0..3
    localparam int unsigned CNT_W       = 2;

    // First fetch address out of reset
    localparam logic [XLEN-1:0] RESET_PC = '0;

    // ====================
    // RV32I major opcodes
    // ====================

    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;

    // B-type layout, immediate bits scattered around the register fields
    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm4_1;
        logic       imm11;
        logic [6:0] opcode;
    } b_fmt_t;

    // J-type layout
    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10_1;
        logic       imm11;
        logic [7:0] imm19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_fmt_t;

    // One instruction word, seen as branch, as jump or as plain bits
    typedef union packed {
        b_fmt_t          b_fmt;
        j_fmt_t          j_fmt;
        logic [XLEN-1:0] raw;
    } rv_inst_u;

endpackage

// File: hw/fetch_group_if.sv
`timescale 1ns/1ps

interface fetch_group_if;

    // Valid slots, always packed from slot 0 upward
    logic [fetch_pkg::CNT_W-1:0] count;
    // Buffer has room for a full group
    logic                        ready;

    // ====================
    // Per-slot payload
    // ====================

    logic [fetch_pkg::XLEN-1:0]        inst [fetch_pkg::FETCH_WIDTH];
    logic [fetch_pkg::XLEN-1:0]        pc   [fetch_pkg::FETCH_WIDTH];
    logic [fetch_pkg::XLEN-1:0]        imm  [fetch_pkg::FETCH_WIDTH];
    logic [fetch_pkg::FETCH_WIDTH-1:0] pred_taken;

    // Fetch side
    modport source (
        output count,
        output inst,
        output pc,
        output imm,
        output pred_taken,
        input  ready
    );

    // Buffer side
    modport sink (
        input  count,
        input  inst,
        input  pc,
        input  imm,
        input  pred_taken,
        output ready
    );

endinterface

// File: hw/imm_predecode.sv
`timescale 1ns/1ps

module imm_predecode (
    input  fetch_pkg::rv_inst_u         inst_i,
    output logic [fetch_pkg::XLEN-1:0]  imm_o,
    output logic                        taken_o
);

    // Major opcode, same position in every format
    logic [6:0] opcode;

    assign opcode = inst_i.raw[6:0];

    // ====================
    // Immediate and static prediction
    // ====================

    always_comb begin
        imm_o   = '0;
        taken_o = 1'b0;
        case (opcode)
            fetch_pkg::OPC_BRANCH: begin
                // 13-bit offset, bit 0 implied zero
                imm_o = {
                    {19{inst_i.b_fmt.imm12}},
                    inst_i.b_fmt.imm12,
                    inst_i.b_fmt.imm11,
                    inst_i.b_fmt.imm10_5,
                    inst_i.b_fmt.imm4_1,
                    1'b0
                };
                // Backward branch assumed to close a loop
                taken_o = inst_i.b_fmt.imm12;
            end
            fetch_pkg::OPC_JAL: begin
                // 21-bit offset
                imm_o = {
                    {11{inst_i.j_fmt.imm20}},
                    inst_i.j_fmt.imm20,
                    inst_i.j_fmt.imm19_12,
                    inst_i.j_fmt.imm11,
                    inst_i.j_fmt.imm10_1,
                    1'b0
                };
                // Unconditional
                taken_o = 1'b1;
            end
            default: begin
                // Not a control transfer, nothing to predict
                imm_o   = '0;
                taken_o = 1'b0;
            end
        endcase
    end

endmodule

// File: hw/multi_fetch.sv
`timescale 1ns/1ps

module multi_fetch (
    input  logic                        clk_i,
    input  logic                        rst_n_i,
    input  logic                        redirect_i,
    input  logic [fetch_pkg::XLEN-1:0]  redirect_pc_i,
    output logic [fetch_pkg::XLEN-1:0]  inst_addr_0_o,
    output logic [fetch_pkg::XLEN-1:0]  inst_addr_1_o,
    output logic [fetch_pkg::XLEN-1:0]  inst_addr_2_o,
    input  logic [fetch_pkg::XLEN-1:0]  instruction_0_i,
    input  logic [fetch_pkg::XLEN-1:0]  instruction_1_i,
    input  logic [fetch_pkg::XLEN-1:0]  instruction_2_i,
    fetch_group_if.source               grp
);

    logic [fetch_pkg::XLEN-1:0]        pc_q;
    logic [fetch_pkg::XLEN-1:0]        next_pc;
    logic [fetch_pkg::XLEN-1:0]        slot_pc    [fetch_pkg::FETCH_WIDTH];
    logic [fetch_pkg::XLEN-1:0]        slot_inst  [fetch_pkg::FETCH_WIDTH];
    logic [fetch_pkg::XLEN-1:0]        slot_imm   [fetch_pkg::FETCH_WIDTH];
    logic [fetch_pkg::FETCH_WIDTH-1:0] slot_taken;

    // Memory returns these in the same cycle
    assign slot_inst[0] = instruction_0_i;
    assign slot_inst[1] = instruction_1_i;
    assign slot_inst[2] = instruction_2_i;

    assign inst_addr_0_o = slot_pc[0];
    assign inst_addr_1_o = slot_pc[1];
    assign inst_addr_2_o = slot_pc[2];

    // ====================
    // Slots and predecode
    // ====================

    for (genvar g = 0; g < fetch_pkg::FETCH_WIDTH; g++) begin : g_slot
        // Consecutive words from the group PC
        assign slot_pc[g] = pc_q + fetch_pkg::XLEN'(4 * g);

        imm_predecode imm_predecode_i (
            .inst_i  (slot_inst[g]),
            .imm_o   (slot_imm[g]),
            .taken_o (slot_taken[g])
        );

        assign grp.inst[g] = slot_inst[g];
        assign grp.pc[g]   = slot_pc[g];
        assign grp.imm[g]  = slot_imm[g];
    end

    assign grp.pred_taken = slot_taken;

    // Cut after the first taken slot and steer to its target
    always_comb begin
        grp.count = fetch_pkg::CNT_W'(fetch_pkg::FETCH_WIDTH);
        next_pc   = pc_q + fetch_pkg::XLEN'(4 * fetch_pkg::FETCH_WIDTH);
        if (slot_taken[0]) begin
            grp.count = fetch_pkg::CNT_W'(1);
            next_pc   = slot_pc[0] + slot_imm[0];
        end else if (slot_taken[1]) begin
            grp.count = fetch_pkg::CNT_W'(2);
            next_pc   = slot_pc[1] + slot_imm[1];
        end else if (slot_taken[2]) begin
            next_pc   = slot_pc[2] + slot_imm[2];
        end
    end

    // ====================
    // PC register
    // ====================

    // Redirect first, else advance only on an accepted group
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            pc_q <= fetch_pkg::RESET_PC;
        end else if (redirect_i) begin
            pc_q <= redirect_pc_i;
        end else if (grp.ready) begin
            pc_q <= next_pc;
        end
    end

    // Targets and redirects must both land on word boundaries
    a_pc_aligned : assert property (@(posedge clk_i) disable iff (!rst_n_i)
        pc_q[1:0] == 2'b00);

endmodule

// File: hw/instruction_buffer.sv
`timescale 1ns/1ps

module instruction_buffer (
    input  logic                         clk_i,
    input  logic                         rst_n_i,
    input  logic                         flush_i,
    fetch_group_if.sink                  grp,
    input  logic [fetch_pkg::CNT_W-1:0]  decode_ready_i,
    output logic [fetch_pkg::CNT_W-1:0]  decode_valid_o,
    output logic [fetch_pkg::XLEN-1:0]   instruction_0_o,
    output logic [fetch_pkg::XLEN-1:0]   instruction_1_o,
    output logic [fetch_pkg::XLEN-1:0]   instruction_2_o,
    output logic [fetch_pkg::XLEN-1:0]   pc_0_o,
    output logic [fetch_pkg::XLEN-1:0]   pc_1_o,
    output logic [fetch_pkg::XLEN-1:0]   pc_2_o,
    output logic [fetch_pkg::XLEN-1:0]   imm_0_o,
    output logic [fetch_pkg::XLEN-1:0]   imm_1_o,
    output logic [fetch_pkg::XLEN-1:0]   imm_2_o,
    output logic                         pred_taken_0_o,
    output logic                         pred_taken_1_o,
    output logic                         pred_taken_2_o,
    output logic                         buffer_empty_o,
    output logic                         buffer_full_o,
    output logic [fetch_pkg::OCC_W-1:0]  occupancy_o
);

    // Entry storage
    logic [fetch_pkg::XLEN-1:0]      mem_inst [fetch_pkg::BUF_DEPTH];
    logic [fetch_pkg::XLEN-1:0]      mem_pc   [fetch_pkg::BUF_DEPTH];
    logic [fetch_pkg::XLEN-1:0]      mem_imm  [fetch_pkg::BUF_DEPTH];
    logic [fetch_pkg::BUF_DEPTH-1:0] mem_pred;

    logic [fetch_pkg::PTR_W-1:0] head_q;
    logic [fetch_pkg::PTR_W-1:0] tail_q;
    logic [fetch_pkg::OCC_W-1:0] occ_q;
    logic                        wr_en;
    logic [fetch_pkg::CNT_W-1:0] wr_cnt;
    logic [fetch_pkg::CNT_W-1:0] rd_cnt;
    logic [fetch_pkg::PTR_W-1:0] rd_addr [fetch_pkg::FETCH_WIDTH];

    // ====================
    // Write side
    // ====================

    // Room for a whole group, whatever its count
    assign grp.ready = (fetch_pkg::OCC_W'(fetch_pkg::BUF_DEPTH) - occ_q)
                       >= fetch_pkg::OCC_W'(fetch_pkg::FETCH_WIDTH);
    // Group fetched during a flush is stale
    assign wr_en  = grp.ready && !flush_i;
    assign wr_cnt = wr_en ? grp.count : '0;

    for (genvar g = 0; g < fetch_pkg::FETCH_WIDTH; g++) begin : g_wr
        logic [fetch_pkg::PTR_W-1:0] wr_addr;

        // Pointer arithmetic wraps at BUF_DEPTH
        assign wr_addr = tail_q + fetch_pkg::PTR_W'(g);

        always_ff @(posedge clk_i) begin
            if (wr_en && (grp.count > fetch_pkg::CNT_W'(g))) begin
                mem_inst[wr_addr] <= grp.inst[g];
                mem_pc[wr_addr]   <= grp.pc[g];
                mem_imm[wr_addr]  <= grp.imm[g];
                mem_pred[wr_addr] <= grp.pred_taken[g];
            end
        end
    end

    // ====================
    // Read side
    // ====================

    // Oldest entries, capped at one decode group
    assign decode_valid_o = (occ_q >= fetch_pkg::OCC_W'(fetch_pkg::FETCH_WIDTH))
                            ? fetch_pkg::CNT_W'(fetch_pkg::FETCH_WIDTH)
                            : occ_q[fetch_pkg::CNT_W-1:0];
    // Decode consumes min(valid, ready)
    assign rd_cnt = (decode_ready_i < decode_valid_o) ? decode_ready_i : decode_valid_o;

    for (genvar g = 0; g < fetch_pkg::FETCH_WIDTH; g++) begin : g_rd
        assign rd_addr[g] = head_q + fetch_pkg::PTR_W'(g);
    end

    assign instruction_0_o = mem_inst[rd_addr[0]];
    assign instruction_1_o = mem_inst[rd_addr[1]];
    assign instruction_2_o = mem_inst[rd_addr[2]];
    assign pc_0_o          = mem_pc[rd_addr[0]];
    assign pc_1_o          = mem_pc[rd_addr[1]];
    assign pc_2_o          = mem_pc[rd_addr[2]];
    assign imm_0_o         = mem_imm[rd_addr[0]];
    assign imm_1_o         = mem_imm[rd_addr[1]];
    assign imm_2_o         = mem_imm[rd_addr[2]];
    assign pred_taken_0_o  = mem_pred[rd_addr[0]];
    assign pred_taken_1_o  = mem_pred[rd_addr[1]];
    assign pred_taken_2_o  = mem_pred[rd_addr[2]];

    // ====================
    // Pointers and status
    // ====================

    always_ff @(posedge clk_i) begin
        if (!rst_n_i || flush_i) begin
            head_q <= '0;
            tail_q <= '0;
            occ_q  <= '0;
        end else begin
            head_q <= head_q + fetch_pkg::PTR_W'(rd_cnt);
            tail_q <= tail_q + fetch_pkg::PTR_W'(wr_cnt);
            occ_q  <= occ_q + fetch_pkg::OCC_W'(wr_cnt) - fetch_pkg::OCC_W'(rd_cnt);
        end
    end

    assign buffer_empty_o = (occ_q == '0);
    assign buffer_full_o  = !grp.ready;
    assign occupancy_o    = occ_q;

    a_occ_bound : assert property (@(posedge clk_i) disable iff (!rst_n_i)
        occ_q <= fetch_pkg::OCC_W'(fetch_pkg::BUF_DEPTH));

    // Not ready means occupancy cannot grow on the next edge
    a_no_write_when_full : assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !grp.ready |=> occ_q <= $past(occ_q));

    a_valid_le_occ : assert property (@(posedge clk_i) disable iff (!rst_n_i)
        fetch_pkg::OCC_W'(decode_valid_o) <= occ_q);

endmodule

// File: hw/fetch_buffer_top.sv
`timescale 1ns/1ps

module fetch_buffer_top (
    input  logic                         clk_i,
    input  logic                         rst_n_i,
    // Instruction memory, three ports
    output logic [fetch_pkg::XLEN-1:0]   inst_addr_0_o,
    output logic [fetch_pkg::XLEN-1:0]   inst_addr_1_o,
    output logic [fetch_pkg::XLEN-1:0]   inst_addr_2_o,
    input  logic [fetch_pkg::XLEN-1:0]   instruction_0_i,
    input  logic [fetch_pkg::XLEN-1:0]   instruction_1_i,
    input  logic [fetch_pkg::XLEN-1:0]   instruction_2_i,
    // Back end correction
    input  logic                         redirect_i,
    input  logic [fetch_pkg::XLEN-1:0]   redirect_pc_i,
    // Decode side
    input  logic [fetch_pkg::CNT_W-1:0]  decode_ready_i,
    output logic [fetch_pkg::CNT_W-1:0]  decode_valid_o,
    output logic [fetch_pkg::XLEN-1:0]   instruction_0_o,
    output logic [fetch_pkg::XLEN-1:0]   instruction_1_o,
    output logic [fetch_pkg::XLEN-1:0]   instruction_2_o,
    output logic [fetch_pkg::XLEN-1:0]   pc_0_o,
    output logic [fetch_pkg::XLEN-1:0]   pc_1_o,
    output logic [fetch_pkg::XLEN-1:0]   pc_2_o,
    output logic [fetch_pkg::XLEN-1:0]   imm_0_o,
    output logic [fetch_pkg::XLEN-1:0]   imm_1_o,
    output logic [fetch_pkg::XLEN-1:0]   imm_2_o,
    output logic                         pred_taken_0_o,
    output logic                         pred_taken_1_o,
    output logic                         pred_taken_2_o,
    // Status
    output logic                         buffer_empty_o,
    output logic                         buffer_full_o,
    output logic [fetch_pkg::OCC_W-1:0]  occupancy_o
);

    // Fetch group link
    fetch_group_if grp_if ();

    multi_fetch multi_fetch_i (
        .clk_i           (clk_i),
        .rst_n_i         (rst_n_i),
        .redirect_i      (redirect_i),
        .redirect_pc_i   (redirect_pc_i),
        .inst_addr_0_o   (inst_addr_0_o),
        .inst_addr_1_o   (inst_addr_1_o),
        .inst_addr_2_o   (inst_addr_2_o),
        .instruction_0_i (instruction_0_i),
        .instruction_1_i (instruction_1_i),
        .instruction_2_i (instruction_2_i),
        .grp             (grp_if.source)
    );

    // Redirect also empties the buffer
    instruction_buffer instruction_buffer_i (
        .clk_i           (clk_i),
        .rst_n_i         (rst_n_i),
        .flush_i         (redirect_i),
        .grp             (grp_if.sink),
        .decode_ready_i  (decode_ready_i),
        .decode_valid_o  (decode_valid_o),
        .instruction_0_o (instruction_0_o),
        .instruction_1_o (instruction_1_o),
        .instruction_2_o (instruction_2_o),
        .pc_0_o          (pc_0_o),
        .pc_1_o          (pc_1_o),
        .pc_2_o          (pc_2_o),
        .imm_0_o         (imm_0_o),
        .imm_1_o         (imm_1_o),
        .imm_2_o         (imm_2_o),
        .pred_taken_0_o  (pred_taken_0_o),
        .pred_taken_1_o  (pred_taken_1_o),
        .pred_taken_2_o  (pred_taken_2_o),
        .buffer_empty_o  (buffer_empty_o),
        .buffer_full_o   (buffer_full_o),
        .occupancy_o     (occupancy_o)
    );

endmodule

// File: bench/fetch_buffer_tb.sv
`timescale 1ns/1ps

module fetch_buffer_tb;

    localparam int N_ROWS = 7;

    logic        clk;
    logic        rst_n_i;
    logic        redirect_i;
    logic [31:0] redirect_pc_i;
    logic [1:0]  decode_ready_i;
    logic [31:0] addr [3];
    logic [31:0] inst_in [3];
    logic [1:0]  decode_valid;
    logic [31:0] out_inst [3];
    logic [31:0] out_pc [3];
    logic [31:0] out_imm [3];
    logic [2:0]  out_pred;
    logic        buffer_empty;
    logic        buffer_full;
    logic [4:0]  occupancy;

    // Program image and what predecode should say about each word
    logic [31:0] imem [64];
    logic [31:0] exp_imm [64];
    logic [63:0] exp_taken;

    // ====================
    // Stimulus table
    // ====================

    string       row_name [N_ROWS] = '{"straight", "loop", "escape", "stall", "release",
                                       "redirect", "random"};
    int          row_cycles [N_ROWS] = '{6, 10, 8, 12, 8, 8, 60};
    // 0..3 fixed decode ready, 4 means random
    int          row_ready [N_ROWS] = '{3, 3, 3, 0, 3, 3, 4};
    logic        row_redir [N_ROWS] = '{1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 1'b1, 1'b0};
    // Word 21 leaves the BNE loop, word 50 is the back end redirect
    logic [31:0] row_pc [N_ROWS] = '{32'd0, 32'd0, 32'd84, 32'd0, 32'd0, 32'd200, 32'd0};
    logic        row_full_chk [N_ROWS] = '{1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0};

    // Reference model and bookkeeping
    logic [31:0] ref_pc;
    logic [5:0]  idx;
    logic [1:0]  n;
    logic        empty_due;
    logic [4:0]  occ_prev;
    int          errors;
    int          row_err;
    int          row_delivered;
    int          tests_pass;
    int          tests_fail;
    int          cycle_cnt = 0;
    int          cycle_limit;

    fetch_buffer_top fetch_buffer_top_i (
        .clk_i           (clk),
        .rst_n_i         (rst_n_i),
        .inst_addr_0_o   (addr[0]),
        .inst_addr_1_o   (addr[1]),
        .inst_addr_2_o   (addr[2]),
        .instruction_0_i (inst_in[0]),
        .instruction_1_i (inst_in[1]),
        .instruction_2_i (inst_in[2]),
        .redirect_i      (redirect_i),
        .redirect_pc_i   (redirect_pc_i),
        .decode_ready_i  (decode_ready_i),
        .decode_valid_o  (decode_valid),
        .instruction_0_o (out_inst[0]),
        .instruction_1_o (out_inst[1]),
        .instruction_2_o (out_inst[2]),
        .pc_0_o          (out_pc[0]),
        .pc_1_o          (out_pc[1]),
        .pc_2_o          (out_pc[2]),
        .imm_0_o         (out_imm[0]),
        .imm_1_o         (out_imm[1]),
        .imm_2_o         (out_imm[2]),
        .pred_taken_0_o  (out_pred[0]),
        .pred_taken_1_o  (out_pred[1]),
        .pred_taken_2_o  (out_pred[2]),
        .buffer_empty_o  (buffer_empty),
        .buffer_full_o   (buffer_full),
        .occupancy_o     (occupancy)
    );

    // Combinational memory, 64 words wrap on the address
    assign inst_in[0] = imem[addr[0][7:2]];
    assign inst_in[1] = imem[addr[1][7:2]];
    assign inst_in[2] = imem[addr[2][7:2]];

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Safety net on the run length
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt > cycle_limit) begin
            $display("Timeout: the run went past %0d cycles without finishing", cycle_limit);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    // ====================
    // Program encoding
    // ====================

    function automatic logic [31:0] encode_branch(input logic [2:0] funct3, input int off);
        fetch_pkg::rv_inst_u u;
        u.raw            = '0;
        u.b_fmt.imm12    = off[12];
        u.b_fmt.imm10_5  = off[10:5];
        u.b_fmt.rs2      = 5'd2;
        u.b_fmt.rs1      = 5'd1;
        u.b_fmt.funct3   = funct3;
        u.b_fmt.imm4_1   = off[4:1];
        u.b_fmt.imm11    = off[11];
        u.b_fmt.opcode   = fetch_pkg::OPC_BRANCH;
        return u.raw;
    endfunction

    function automatic logic [31:0] encode_jal(input int off);
        fetch_pkg::rv_inst_u u;
        u.raw            = '0;
        u.j_fmt.imm20    = off[20];
        u.j_fmt.imm10_1  = off[10:1];
        u.j_fmt.imm11    = off[11];
        u.j_fmt.imm19_12 = off[19:12];
        u.j_fmt.rd       = 5'd1;
        u.j_fmt.opcode   = fetch_pkg::OPC_JAL;
        return u.raw;
    endfunction

    task load_program();
        // ADDI x1, x1, word index everywhere else
        for (int i = 0; i < 64; i++) begin
            imem[i]      = {12'(i), 5'd1, 3'b000, 5'd1, 7'b0010011};
            exp_imm[i]   = '0;
            exp_taken[i] = 1'b0;
        end
        // Forward BEQ, not taken
        imem[5]       = encode_branch(3'b000, 12);
        exp_imm[5]    = 32'd12;
        // Backward BNE to word 12
        imem[20]      = encode_branch(3'b001, -32);
        exp_imm[20]   = 32'hffff_ffe0;
        exp_taken[20] = 1'b1;
        // JAL to word 40
        imem[30]      = encode_jal(40);
        exp_imm[30]   = 32'd40;
        exp_taken[30] = 1'b1;
    endtask

    // ====================
    // Checks
    // ====================

    task sample_and_compare();
        if (empty_due && !buffer_empty) begin
            $display("Error at %0t: buffer not empty the cycle after a redirect", $time);
            row_err++;
        end
        empty_due = 1'b0;
        // Full once fewer than three entries are free
        if (buffer_full !== (occupancy > 5'd13)) begin
            $display("Error at %0t: buffer_full_o %b with occupancy %0d", $time,
                     buffer_full, occupancy);
            row_err++;
        end
        // Empty only at zero occupancy
        if (buffer_empty !== (occupancy == 5'd0)) begin
            $display("Error at %0t: buffer_empty_o %b with occupancy %0d", $time,
                     buffer_empty, occupancy);
            row_err++;
        end
        // Decode sees the oldest entries, at most one group
        if (decode_valid !== ((occupancy > 5'd3) ? 2'd3 : occupancy[1:0])) begin
            $display("Error at %0t: decode_valid_o %0d with occupancy %0d", $time,
                     decode_valid, occupancy);
            row_err++;
        end
        if (redirect_i) begin
            // Flush drops everything shown this cycle
            ref_pc    = redirect_pc_i;
            empty_due = 1'b1;
        end else begin
            n = (decode_ready_i < decode_valid) ? decode_ready_i : decode_valid;
            for (int k = 0; k < int'(n); k++) begin
                idx = ref_pc[7:2];
                if (out_pc[k] !== ref_pc || out_inst[k] !== imem[idx] ||
                    out_imm[k] !== exp_imm[idx] || out_pred[k] !== exp_taken[idx]) begin
                    $display("Error at %0t: slot %0d got pc %h inst %h imm %h pred %b",
                             $time, k, out_pc[k], out_inst[k], out_imm[k], out_pred[k]);
                    $display("    expected pc %h inst %h imm %h pred %b",
                             ref_pc, imem[idx], exp_imm[idx], exp_taken[idx]);
                    row_err++;
                end
                // Static rule: follow the predicted target
                ref_pc = exp_taken[idx] ? ref_pc + exp_imm[idx] : ref_pc + 32'd4;
                row_delivered++;
            end
        end
    endtask

    task report_row(input string name);
        if (row_err == 0) begin
            tests_pass++;
            $display("Test %s: ok", name);
        end else begin
            tests_fail++;
            $display("Test %s: %0d mismatches", name, row_err);
        end
        errors += row_err;
    endtask

    initial begin
        rst_n_i        = 1'b0;
        redirect_i     = 1'b0;
        redirect_pc_i  = '0;
        decode_ready_i = '0;
        void'($urandom(32'h83ed_d6dd));
        load_program();
        cycle_limit = 100;
        for (int r = 0; r < N_ROWS; r++) begin
            cycle_limit += row_cycles[r];
        end
        ref_pc     = fetch_pkg::RESET_PC;
        empty_due  = 1'b0;
        occ_prev   = '0;
        errors     = 0;
        tests_pass = 0;
        tests_fail = 0;

        repeat (16) @(posedge clk);
        rst_n_i <= 1'b1;
        @(negedge clk);
        row_err = 0;
        if (decode_valid !== 2'd0 || buffer_empty !== 1'b1 || buffer_full !== 1'b0) begin
            $display("Error at %0t: after reset valid %0d empty %b full %b", $time,
                     decode_valid, buffer_empty, buffer_full);
            row_err++;
        end
        report_row("reset");

        for (int r = 0; r < N_ROWS; r++) begin
            row_err       = 0;
            row_delivered = 0;
            for (int c = 0; c < row_cycles[r]; c++) begin
                @(posedge clk);
                decode_ready_i <= (row_ready[r] > 3) ? 2'($urandom) : 2'(row_ready[r]);
                redirect_i     <= row_redir[r] && (c == 0);
                redirect_pc_i  <= row_pc[r];
                @(negedge clk);
                sample_and_compare();
                // Stalled buffer must have settled full
                if (row_full_chk[r] && c == row_cycles[r] - 1) begin
                    if (!buffer_full || occupancy < 5'd14 || occupancy !== occ_prev) begin
                        $display("Error at %0t: stall ended with occupancy %0d, before %0d",
                                 $time, occupancy, occ_prev);
                        row_err++;
                    end
                end
                occ_prev = occupancy;
            end
            if (row_ready[r] != 0 && row_delivered == 0) begin
                $display("Test %s delivered no instructions, the stream stalled", row_name[r]);
                row_err++;
            end
            report_row(row_name[r]);
        end

        $display("Summary: %0d tests, %0d ok, %0d with mismatches, %0d mismatches in total",
                 tests_pass + tests_fail, tests_pass, tests_fail, errors);
        if (tests_fail == 0 && errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// File: project.f
hw/fetch_pkg.sv
hw/fetch_group_if.sv
hw/imm_predecode.sv
hw/multi_fetch.sv
hw/instruction_buffer.sv
hw/fetch_buffer_top.sv
bench/fetch_buffer_tb.sv

// File: run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module fetch_buffer_tb \
    -f project.f -o fetch_buffer_sim &&
./obj_dir/fetch_buffer_sim | tee /dev/stderr | grep "SIMULATION PASSED" > /dev/null &&
echo "run_sim: pass" || { echo "run_sim: fail"; exit 1; }
